/* bomb_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module bomb_assert (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic req0,
  input wire logic req1,
  input wire logic ready0,
  input wire logic ready1,
  input wire logic explode
);

  // one write per cycle on the map port
  a_one_ready: assert property (@(posedge clk) disable iff (!rst_n) !(ready0 && ready1))
    else $error("both ready high");

  // grant only to a requester
  a_ready_req: assert property (@(posedge clk) disable iff (!rst_n)
    (ready0 -> req0) && (ready1 -> req1))
    else $error("ready without req");

  a_explode_once: assert property (@(posedge clk) disable iff (!rst_n) explode |=> !explode)
    else $error("explode longer than one cycle");

endmodule

bind map_write_arbiter bomb_assert u_arb_assert (
  .clk(clk), .rst_n(rst_n), .req0(req0), .req1(req1),
  .ready0(ready0), .ready1(ready1), .explode(1'b0)
);

bind bomb_unit bomb_assert u_unit_assert (
  .clk(clk), .rst_n(rst_n), .req0(req), .req1(1'b0),
  .ready0(ready), .ready1(1'b0), .explode(explode)
);

`default_nettype wire

/* bomb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module bomb_checker import bomber_pkg::*; (
  input wire logic              clk,
  input wire logic              rst_n,
  input wire logic              tick,
  input wire logic              game_over,
  input wire logic [addr_w-1:0] rd_addr,
  input wire logic [tile_w-1:0] rd_data,
  input wire logic [1:0]        explode,
  input wire logic [1:0]        bomb_active
);

  int err_cnt  = 0;          // every mismatch and timeout
  int test_cnt = 0;
  int fail_cnt = 0;          // tests with at least one error
  int test_err0;             // err_cnt when the test began
  string test_name;
  int tick_cnt [2];          // fuse ticks since bomb_active rose
  int explode_cnt [2];       // explode pulses seen per player
  logic [1:0] explode_q;     // for rising edge of explode

  task automatic value_fail(input string sig, input int exp, input int got);
    $display("[FAIL] t=%0t %s exp=%0d got=%0d", $time, sig, exp, got);
    err_cnt++;
  endtask

  // ----------------------------------------
  // per-test bookkeeping
  // ----------------------------------------
  task automatic start_test(input string name);
    test_name = name;
    test_err0 = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    if (err_cnt == test_err0) begin
      $display("test %0d %s: ok", test_cnt, test_name);
    end else begin
      $display("test %0d %s: failed, %0d errors", test_cnt, test_name, err_cnt - test_err0);
      fail_cnt++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at t=%0t while waiting for %s", $time, what);
    err_cnt++;
  endtask

  // ----------------------------------------
  // comparisons called from the testbench
  // ----------------------------------------
  // tile under sprite centre, row * num_col + col
  task automatic check_addr(input int x, input int y, input int file_addr);
    int exp;
    exp = ((y + sprite_h / 2) >> tile_shift) * num_col + ((x + sprite_w / 2) >> tile_shift);
    if (exp != file_addr) value_fail("tile_addr", exp, file_addr);
  endtask

  task automatic check_tile(input int exp);
    if (int'(rd_data) != exp) value_fail($sformatf("rd_data[%0d]", rd_addr), exp, rd_data);
  endtask

  task automatic check_active(input int p, input int exp);
    if (int'(bomb_active[p]) != exp) value_fail($sformatf("bomb_active[%0d]", p), exp,
                                                bomb_active[p]);
  endtask

  task automatic check_explode_count(input int p, input int exp);
    if (explode_cnt[p] != exp) value_fail($sformatf("explode_count[%0d]", p), exp,
                                          explode_cnt[p]);
  endtask

  // ----------------------------------------
  // fuse monitor, samples pre-edge values
  // ----------------------------------------
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tick_cnt    = '{0, 0};
      explode_cnt = '{0, 0};
      explode_q   = 2'b00;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (game_over) begin
          tick_cnt[p] = 0;  // bomb dropped
        end else if (explode[p] && !explode_q[p]) begin
          explode_cnt[p]++;
          if (tick_cnt[p] != fuse_ticks)
            value_fail($sformatf("fuse_ticks[%0d]", p), fuse_ticks, tick_cnt[p]);
          tick_cnt[p] = 0;
        end else if (bomb_active[p] && tick) begin
          tick_cnt[p]++;
        end
      end
      explode_q = explode;
    end
  end

endmodule

`default_nettype wire

/* bomb_input.txt */
# kind p0_x p0_y p1_x p1_y addr0 addr1  (decimal)
# kind 1/2 place+fuse for p0/p1, 3 single bomb (p1 cols = p0 second spot)
# kind 4 both players at once, 5 game over during fuse
1 100 50 0 0 43 0
1 16 15 0 0 1 0
2 0 0 300 200 0 129
3 64 64 400 300 42 193
4 10 10 620 460 0 299
5 200 100 500 150 66 116

/* bomb_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bomb_subsystem_top import bomber_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              tick,
  input  wire logic              game_over,
  // player 0
  input  wire logic [px_x_w-1:0] p0_x,
  input  wire logic [px_y_w-1:0] p0_y,
  input  wire logic              p0_place,
  // player 1
  input  wire logic [px_x_w-1:0] p1_x,
  input  wire logic [px_y_w-1:0] p1_y,
  input  wire logic              p1_place,
  // map read side
  input  wire logic [addr_w-1:0] rd_addr,
  output logic [tile_w-1:0]      rd_data,
  output logic [1:0]             explode,      // bit per player
  output logic [1:0]             bomb_active   // fuse running
);

  // ----------------------------------------
  // unit to arbiter
  // ----------------------------------------
  logic              req0, req1;
  logic [addr_w-1:0] addr0, addr1;
  logic [tile_w-1:0] data0, data1;
  logic              ready0, ready1;

  // arbiter to map
  logic              wr_en;
  logic [addr_w-1:0] wr_addr;
  logic [tile_w-1:0] wr_data;

  bomb_unit u_bomb0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .tick     (tick),
    .game_over(game_over),
    .pos_x    (p0_x),
    .pos_y    (p0_y),
    .place    (p0_place),
    .ready    (ready0),
    .req      (req0),
    .req_addr (addr0),
    .req_data (data0),
    .explode  (explode[0]),
    .active   (bomb_active[0])
  );

  bomb_unit u_bomb1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .tick     (tick),
    .game_over(game_over),
    .pos_x    (p1_x),
    .pos_y    (p1_y),
    .place    (p1_place),
    .ready    (ready1),
    .req      (req1),
    .req_addr (addr1),
    .req_data (data1),
    .explode  (explode[1]),
    .active   (bomb_active[1])
  );

  map_write_arbiter u_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .game_over(game_over),
    .req0     (req0),
    .addr0    (addr0),
    .data0    (data0),
    .req1     (req1),
    .addr1    (addr1),
    .data1    (data1),
    .ready0   (ready0),
    .ready1   (ready1),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  tile_map u_tile_map (
    .clk      (clk),
    .rst_n    (rst_n),
    .game_over(game_over),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

`default_nettype wire

/* bomb_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module bomb_unit import bomber_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              tick,       // one-cycle frame pulse
  input  wire logic              game_over,
  input  wire logic [px_x_w-1:0] pos_x,      // sprite top-left x
  input  wire logic [px_y_w-1:0] pos_y,      // sprite top-left y
  input  wire logic              place,      // raw button
  input  wire logic              ready,      // write accepted this cycle
  output logic                   req,
  output logic [addr_w-1:0]      req_addr,
  output logic [tile_w-1:0]      req_data,
  output logic                   explode,
  output logic                   active
);

  logic place_s1, place_s2;           // button sync chain
  logic place_pulse;                  // fresh press
  bomb_state_t state, state_nxt;
  logic [fuse_cnt_w-1:0] fuse_cnt;    // ticks seen in fuse
  logic fuse_done;
  logic fired;                        // explode already shown
  logic [px_x_w-1:0] center_x;
  logic [px_y_w-1:0] center_y;
  logic [row_w-1:0] tile_row;
  logic [col_w-1:0] tile_col;
  logic [addr_w-1:0] tile_addr;       // tile under sprite centre
  logic [addr_w-1:0] bomb_addr;       // held for both writes

  // ----------------------------------------
  // button sync and edge detect
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      place_s1 <= 1'b0;
      place_s2 <= 1'b0;
    end else if (game_over) begin
      place_s1 <= 1'b0;
      place_s2 <= 1'b0;
    end else begin
      place_s1 <= place;
      place_s2 <= place_s1;
    end
  end

  assign place_pulse = place_s1 & ~place_s2;  // only honoured in idle

  // ----------------------------------------
  // centre tile address
  // ----------------------------------------
  assign center_x  = pos_x + px_x_w'(sprite_w / 2);
  assign center_y  = pos_y + px_y_w'(sprite_h / 2);
  assign tile_col  = center_x[tile_shift +: col_w];  // divide by tile_px
  assign tile_row  = center_y[tile_shift +: row_w];
  assign tile_addr = addr_w'(tile_row * num_col + tile_col);

  // ----------------------------------------
  // fuse FSM
  // ----------------------------------------
  assign fuse_done = tick && (fuse_cnt == fuse_cnt_w'(fuse_ticks - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      bomb_idle:    if (place_pulse) state_nxt = bomb_place;
      bomb_place:   if (ready) state_nxt = bomb_fuse;     // bomb tile written
      bomb_fuse:    if (fuse_done) state_nxt = bomb_explode;
      bomb_explode: if (ready) state_nxt = bomb_idle;     // tile freed
      default:      state_nxt = bomb_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= bomb_idle;
      fuse_cnt <= '0;
      fired    <= 1'b0;
    end else if (game_over) begin
      state    <= bomb_idle;  // bomb dropped, no explode
      fuse_cnt <= '0;
      fired    <= 1'b0;
    end else begin
      state <= state_nxt;
      fired <= (state == bomb_explode);  // high from 2nd explode cycle on
      if (state != bomb_fuse)
        fuse_cnt <= '0;
      else if (tick)
        fuse_cnt <= fuse_cnt + 1'b1;
    end
  end

  // address captured on the press, reused for the free write
  always_ff @(posedge clk) begin
    if (state == bomb_idle && place_pulse)
      bomb_addr <= tile_addr;
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  assign req      = (state == bomb_place) || (state == bomb_explode);
  assign req_addr = bomb_addr;
  assign req_data = (state == bomb_explode) ? tile_empty : tile_bomb;
  assign explode  = (state == bomb_explode) && !fired;  // single cycle
  assign active   = (state == bomb_fuse);

endmodule

`default_nettype wire

/* bomber_pkg.sv */
`default_nettype none

package bomber_pkg;

  // ----------------------------------------
  // map geometry
  // ----------------------------------------
  localparam int num_row   = 15;                  // tiles down
  localparam int num_col   = 20;                  // tiles across
  localparam int map_depth = num_row * num_col;   // 300 cells
  localparam int addr_w    = $clog2(map_depth);   // 9 bits
  localparam int row_w     = $clog2(num_row);     // row index width
  localparam int col_w     = $clog2(num_col);     // col index width

  localparam int tile_px    = 32;                 // tile edge in pixels
  localparam int tile_shift = $clog2(tile_px);    // pixel -> tile divide

  // sprite box, position is its top-left corner
  localparam int sprite_w = 32;
  localparam int sprite_h = 32;
  localparam int px_x_w   = 11;                   // x up to 2047
  localparam int px_y_w   = 10;                   // y up to 1023

  // ----------------------------------------
  // tile codes
  // ----------------------------------------
  localparam int tile_w = 2;
  localparam logic [tile_w-1:0] tile_empty = 2'd0;
  localparam logic [tile_w-1:0] tile_wall  = 2'd1;  // also returned off-map
  localparam logic [tile_w-1:0] tile_bomb  = 2'd3;

  // ----------------------------------------
  // fuse timing, counted in frame ticks
  // ----------------------------------------
  localparam int ticks_per_sec = 60;
  localparam int bomb_seconds  = 3;
  localparam int fuse_ticks    = ticks_per_sec * bomb_seconds;  // 180
  localparam int fuse_cnt_w    = $clog2(fuse_ticks);

  // bomb unit states
  typedef enum logic [1:0] {
    bomb_idle    = 2'd0,  // waiting for a press
    bomb_place   = 2'd1,  // bomb write pending
    bomb_fuse    = 2'd2,  // counting ticks
    bomb_explode = 2'd3   // free write pending
  } bomb_state_t;

endpackage

`default_nettype wire

/* flist.f */
bomber_pkg.sv
bomb_unit.sv
map_write_arbiter.sv
tile_map.sv
bomb_subsystem_top.sv
bomb_checker.sv
bomb_assert.sv
tb_bomb_subsystem.sv

/* map_write_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module map_write_arbiter import bomber_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              game_over,
  // unit 0 request
  input  wire logic              req0,
  input  wire logic [addr_w-1:0] addr0,
  input  wire logic [tile_w-1:0] data0,
  // unit 1 request
  input  wire logic              req1,
  input  wire logic [addr_w-1:0] addr1,
  input  wire logic [tile_w-1:0] data1,
  output logic                   ready0,
  output logic                   ready1,
  // tile map write port
  output logic                   wr_en,
  output logic [addr_w-1:0]      wr_addr,
  output logic [tile_w-1:0]      wr_data
);

  logic last_grant;  // 0 = unit 0 won last, 1 = unit 1
  logic gnt0, gnt1;

  // ----------------------------------------
  // grant decision
  // ----------------------------------------
  // lone request wins at once, on a tie the unit not served last wins
  assign gnt0 = req0 & (~req1 | last_grant);
  assign gnt1 = req1 & (~req0 | ~last_grant);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      last_grant <= 1'b0;
    else if (game_over)
      last_grant <= 1'b0;
    else if (gnt0 | gnt1)
      last_grant <= gnt1;  // remember the winner
  end

  // ----------------------------------------
  // write port mux
  // ----------------------------------------
  assign ready0  = gnt0;
  assign ready1  = gnt1;
  assign wr_en   = gnt0 | gnt1;
  assign wr_addr = gnt1 ? addr1 : addr0;  // unit 0 side when idle
  assign wr_data = gnt1 ? data1 : data0;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the bomb subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_bomb_subsystem -f flist.f -o sim_bomb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_bomb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^>>> PASS$" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

/* tb_bomb_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bomb_subsystem import bomber_pkg::*; ();

  logic              clk = 1'b0;
  logic              rst_n;
  logic              tick;
  logic              game_over;
  logic [px_x_w-1:0] p0_x, p1_x;
  logic [px_y_w-1:0] p0_y, p1_y;
  logic              p0_place, p1_place;
  logic [addr_w-1:0] rd_addr;
  logic [tile_w-1:0] rd_data;
  logic [1:0]        explode;
  logic [1:0]        bomb_active;

  int fd;
  int kind, x0, y0, x1, y1, a0, a1;
  int base0, base1;          // explode counts before a test
  reg [8*128-1:0] line;

  always #5 clk = ~clk;      // 10 ns period

  bomb_subsystem_top i_bomb_subsystem_top (
    .clk(clk), .rst_n(rst_n), .tick(tick), .game_over(game_over),
    .p0_x(p0_x), .p0_y(p0_y), .p0_place(p0_place),
    .p1_x(p1_x), .p1_y(p1_y), .p1_place(p1_place),
    .rd_addr(rd_addr), .rd_data(rd_data), .explode(explode), .bomb_active(bomb_active)
  );

  bomb_checker i_checker (
    .clk(clk), .rst_n(rst_n), .tick(tick), .game_over(game_over), .rd_addr(rd_addr),
    .rd_data(rd_data), .explode(explode), .bomb_active(bomb_active)
  );

  // ----------------------------------------
  // helpers, all inputs move on negedge
  // ----------------------------------------
  task automatic set_read(input int addr);
    @(negedge clk);
    rd_addr = addr_w'(addr);
    #1;                      // let the combinational read settle
  endtask

  task automatic wait_tile(input int addr, input int code, input int limit);
    int n;
    n = 0;
    set_read(addr);
    while (int'(rd_data) != code && n < limit) begin
      set_read(addr);
      n++;
    end
    if (n >= limit) i_checker.report_timeout($sformatf("tile %0d to hold code %0d", addr, code));
    i_checker.check_tile(code);
  endtask

  task automatic wait_explode(input int p, input int limit);
    int n;
    n = 0;
    while (!explode[p] && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (n >= limit) i_checker.report_timeout($sformatf("explode of player %0d", p));
  endtask

  // both pulses, in whichever order the arbiter let the fuses start
  task automatic wait_explode_pair(input int limit);
    int n;
    logic [1:0] seen;
    n = 0;
    seen = 2'b00;
    while (seen != 2'b11 && n < limit) begin
      @(negedge clk);
      seen = seen | explode;
      n++;
    end
    if (seen != 2'b11) i_checker.report_timeout("explode of both players");
  endtask

  task automatic idle_gap();
    repeat ($urandom_range(9, 2)) @(negedge clk);
  endtask

  task automatic release_buttons();
    @(negedge clk);
    p0_place = 1'b0;
    p1_place = 1'b0;
  endtask

  // ----------------------------------------
  // one test per data line
  // ----------------------------------------
  task automatic run_single(input int p);
    int a;
    a = (p == 0) ? a0 : a1;
    i_checker.start_test($sformatf("place_fuse_p%0d", p));
    @(negedge clk);
    if (p == 0) p0_place = 1'b1;
    else p1_place = 1'b1;
    wait_tile(a, tile_bomb, 4);
    release_buttons();
    i_checker.check_active(p, 1);
    wait_explode(p, fuse_ticks + 10);
    wait_tile(a, tile_empty, 3);       // free write right after the pulse
    i_checker.check_active(p, 0);
    i_checker.check_explode_count(p, ((p == 0) ? base0 : base1) + 1);
    i_checker.end_test();
  endtask

  task automatic run_single_bomb();
    i_checker.start_test("single_bomb");
    @(negedge clk);
    p0_place = 1'b1;
    wait_tile(a0, tile_bomb, 4);
    repeat (20) @(negedge clk);       // held button, no second bomb
    p0_place = 1'b0;
    repeat (3) @(negedge clk);
    p0_x = px_x_w'(x1);               // move, then press again mid-fuse
    p0_y = px_y_w'(y1);
    p0_place = 1'b1;
    repeat (6) @(negedge clk);
    release_buttons();
    set_read(a1);
    i_checker.check_tile(tile_empty);
    set_read(a0);
    i_checker.check_tile(tile_bomb);
    wait_explode(0, fuse_ticks + 10);
    wait_tile(a0, tile_empty, 3);
    repeat (10) @(negedge clk);
    set_read(a1);                     // no late bomb at the new spot
    i_checker.check_tile(tile_empty);
    i_checker.check_explode_count(0, base0 + 1);
    i_checker.end_test();
  endtask

  task automatic run_both(input int with_game_over);
    i_checker.start_test(with_game_over ? "game_over" : "both_players");
    @(negedge clk);
    p0_place = 1'b1;
    p1_place = 1'b1;                  // same cycle, arbiter serializes
    wait_tile(a0, tile_bomb, 5);
    wait_tile(a1, tile_bomb, 5);
    release_buttons();
    if (with_game_over) begin
      repeat (10) @(negedge clk);
      game_over = 1'b1;
      @(negedge clk);
      game_over = 1'b0;
      set_read(a0);
      i_checker.check_tile(tile_empty);
      set_read(a1);
      i_checker.check_tile(tile_empty);
      i_checker.check_active(0, 0);
      i_checker.check_active(1, 0);
      repeat (200) @(negedge clk);    // tick high, 200 ticks
      i_checker.check_explode_count(0, base0);
      i_checker.check_explode_count(1, base1);
    end else begin
      wait_explode_pair(fuse_ticks + 10);
      wait_tile(a0, tile_empty, 3);
      wait_tile(a1, tile_empty, 3);
      i_checker.check_explode_count(0, base0 + 1);
      i_checker.check_explode_count(1, base1 + 1);
    end
    i_checker.end_test();
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    void'($urandom(20));
    rst_n = 1'b0;
    tick = 1'b1;                      // held high, one tick per cycle
    game_over = 1'b0;
    p0_x = '0;
    p0_y = '0;
    p1_x = '0;
    p1_y = '0;
    p0_place = 1'b0;
    p1_place = 1'b0;
    rd_addr = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    fd = $fopen("bomb_input.txt", "r");
    if (fd == 0) begin
      $display("could not open bomb_input.txt");
      $display(">>> FAIL");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) == 0) break;
        if ($sscanf(line, "%d %d %d %d %d %d %d", kind, x0, y0, x1, y1, a0, a1) != 7)
          continue;                   // header and blank lines
        @(negedge clk);
        p0_x = px_x_w'(x0);
        p0_y = px_y_w'(y0);
        p1_x = px_x_w'(x1);
        p1_y = px_y_w'(y1);
        base0 = i_checker.explode_cnt[0];
        base1 = i_checker.explode_cnt[1];
        i_checker.check_addr(x0, y0, a0);
        i_checker.check_addr(x1, y1, a1);
        case (kind)
          1: run_single(0);
          2: run_single(1);
          3: run_single_bomb();
          4: run_both(0);
          5: run_both(1);
          default: $display("unknown test kind %0d skipped", kind);
        endcase
        idle_gap();
      end
      $fclose(fd);
      $display("tests %0d, failed %0d, errors %0d", i_checker.test_cnt,
               i_checker.fail_cnt, i_checker.err_cnt);
      if (i_checker.err_cnt == 0 && i_checker.test_cnt > 0)
        $display(">>> PASS");
      else
        $display(">>> FAIL");
      $finish;
    end
  end

  // watchdog for the whole run
  initial begin
    #2ms;
    $display("simulation ran past its time limit");
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* tile_map.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_map import bomber_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              game_over,  // wipes every cell
  input  wire logic              wr_en,
  input  wire logic [addr_w-1:0] wr_addr,
  input  wire logic [tile_w-1:0] wr_data,
  input  wire logic [addr_w-1:0] rd_addr,
  output logic [tile_w-1:0]      rd_data
);

  logic [tile_w-1:0] cells [map_depth];  // one code per map cell
  logic wr_ok;
  logic rd_ok;

  // 9-bit addresses reach past the 300 cells
  assign wr_ok = (wr_addr < addr_w'(map_depth));
  assign rd_ok = (rd_addr < addr_w'(map_depth));

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < map_depth; i++)
        cells[i] <= tile_empty;
    end else if (game_over) begin
      for (int i = 0; i < map_depth; i++)
        cells[i] <= tile_empty;  // clear wins over a same-cycle write
    end else if (wr_en && wr_ok) begin
      cells[wr_addr] <= wr_data;
    end
  end

  // ----------------------------------------
  // read port, combinational
  // ----------------------------------------
  always_comb begin
    if (rd_ok)
      rd_data = cells[rd_addr];
    else
      rd_data = tile_wall;  // off the map looks solid
  end

endmodule

`default_nettype wire
